// File: common/glbl_settings.svh
// Global register block settings
// Register addresses, strap bit positions, chip ID and reset values
`ifndef GLBL_SETTINGS_SVH
`define GLBL_SETTINGS_SVH

// Word addresses on the register bus
`define ADDR_CHIP_ID               0
`define ADDR_RST_CTRL              1
`define ADDR_GLBL_CFG              2
`define ADDR_IRQ_MASK              3
`define ADDR_IRQ_STAT              4
`define ADDR_MFUNC_SEL             5
`define ADDR_SYS_STRAP             14
`define ADDR_MAILBOX               15
`define ADDR_SW_REG0               16
`define NUM_SW_REGS                8

// Manufacturer 8268h, one core, chip id 5, revision 01h
`define CHIP_ID_WORD               32'h8268_1501

// System strap bit positions
`define STRAP_RISCV_RESET_MODE     0
`define STRAP_RISCV_CACHE_BYPASS   1
`define STRAP_RISCV_SRAM_CLK_EDGE  2

// Reset control, bit 8 added when the boot strap releases core 0
`define RST_CTRL_DEFAULT           32'h0000_0003
`define RST_CTRL_BOOT_BIT          8
`define RST_BIT_CPU_INTF           0
`define RST_BIT_QSPIM              1
`define RST_BIT_SSPIM              2
`define RST_BIT_UART0              3
`define RST_BIT_I2CM               4
`define RST_BIT_USB                5
`define RST_BIT_UART1              6
`define RST_BIT_CPU_CORE           8

// Writable bits of the config word: 31:16, 8 and 3:0
`define GLBL_CFG_MASK              32'hFFFF_010F
`define MFUNC_SEL_DEFAULT          32'h8000_0000

// Software register reset words
`define SW_SIGNATURE               32'h8273_8343
`define SW_RELEASE_DATE            32'h1508_2022
`define SW_REVISION                32'h0005_2000

`endif

// File: common/glbl_pkg.sv
// Global register block types
// Word, address, byte-enable, select and interrupt vector types
`default_nettype none

package glbl_pkg;

   //----------------------------------------
   // Bus side
   //----------------------------------------

   // One register word
   typedef logic [31:0] reg_data_t;

   // Word address, 32 locations
   typedef logic [4:0]  reg_addr_t;

   // One enable per byte lane
   typedef logic [3:0]  reg_be_t;

   // One-hot decode, bit n selects address n
   typedef logic [31:0] reg_sel_t;

   //----------------------------------------
   // Interrupts
   //----------------------------------------

   // Sources, mask, status and lines share this width
   typedef logic [31:0] irq_vec_t;

endpackage

`default_nettype wire

// File: design/reg_bus_ctrl.sv
// Register bus controller
// Address decode, write strobe, one-cycle acknowledge and read capture
`timescale 1ns/1ps
`include "glbl_settings.svh"
`default_nettype none

module reg_bus_ctrl
   import glbl_pkg::*;
(
   input  wire logic      mclk,
   input  wire logic      s_reset_n,
   // Host side
   input  wire logic      reg_cs,
   input  wire logic      reg_wr,
   input  wire reg_addr_t reg_addr,
   input  wire reg_data_t reg_wdata,
   input  wire reg_be_t   reg_be,
   // Live strap readable as a register
   input  wire reg_data_t system_strap,
   // Read words from the register sets
   input  wire reg_data_t bank_rdata,
   input  wire reg_data_t irq_rdata,
   // Towards the register sets
   output reg_sel_t       reg_sel,
   output logic           wr_stb,
   output reg_data_t      wr_data,
   output reg_be_t        wr_be,
   // Host side response
   output reg_data_t      reg_rdata,
   output logic           reg_ack
);

   localparam reg_data_t CHIP_ID = `CHIP_ID_WORD;

   // Access taken this cycle
   logic      access;
   reg_data_t rd_word;

   //----------------------------------------
   // Decode
   //----------------------------------------

   // New access only when no ack is pending
   assign access  = reg_cs & ~reg_ack;

   // Full 5-bit decode with a bit per address
   assign reg_sel = reg_sel_t'(1) << reg_addr;

   // Commit lands on the edge that raises ack
   assign wr_stb  = access & reg_wr;
   assign wr_data = reg_wdata;
   assign wr_be   = reg_be;

   //----------------------------------------
   // Read word
   //----------------------------------------

   // Sets return zero when not selected so a plain OR merges them
   // Chip ID and strap live here
   assign rd_word = bank_rdata
                  | irq_rdata
                  | ({32{reg_sel[`ADDR_CHIP_ID]}} & CHIP_ID)
                  | ({32{reg_sel[`ADDR_SYS_STRAP]}} & system_strap);

   //----------------------------------------
   // Acknowledge and capture
   //----------------------------------------

   // Ack pulses for one cycle per access
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         reg_ack <= 1'b0;
      end else begin
         reg_ack <= access;
      end
   end

   // Word as it was before the commit edge
   always_ff @(posedge mclk) begin
      if (access) begin
         reg_rdata <= rd_word;
      end
   end

   // Back-to-back cs still leaves a gap cycle between acks
   a_ack_single : assert property (
      @(posedge mclk) disable iff (!s_reset_n)
      reg_ack |=> !reg_ack
   );

   // Decode drives exactly one register
   a_sel_onehot : assert property (
      @(posedge mclk) disable iff (!s_reset_n)
      $onehot(reg_sel)
   );

endmodule

`default_nettype wire

// File: design/cfg_reg_bank.sv
// Configuration register bank
// Reset control, global config, pin select, mailbox and software words
// Byte writable with fields unpacked to the output ports
`timescale 1ns/1ps
`include "glbl_settings.svh"
`default_nettype none

module cfg_reg_bank
   import glbl_pkg::*;
(
   input  wire logic      mclk,
   input  wire logic      s_reset_n,
   input  wire reg_data_t system_strap,
   // Decoded write from the bus controller
   input  wire reg_sel_t  reg_sel,
   input  wire logic      wr_stb,
   input  wire reg_data_t wr_data,
   input  wire reg_be_t   wr_be,
   output reg_data_t      bank_rdata,
   // Config fields
   output logic           soft_irq,
   output logic [2:0]     user_irq,
   output logic [15:0]    cfg_riscv_ctrl,
   output logic           cfg_gpio_dgmode,
   output reg_data_t      cfg_multi_func_sel,
   // Resets
   output logic [3:0]     cpu_core_rst_n,
   output logic           cpu_intf_rst_n,
   output logic           qspim_rst_n,
   output logic           sspim_rst_n,
   output logic [1:0]     uart_rst_n,
   output logic           i2cm_rst_n,
   output logic           usb_rst_n
);

   localparam reg_data_t CFG_MASK = `GLBL_CFG_MASK;
   // First three hold signature, release date and revision
   localparam reg_data_t SW_INIT [`NUM_SW_REGS] =
      '{0: `SW_SIGNATURE, 1: `SW_RELEASE_DATE, 2: `SW_REVISION, default: '0};

   reg_data_t rst_ctrl;
   reg_data_t glbl_cfg;
   reg_data_t mfunc_sel;
   reg_data_t mailbox;
   reg_data_t sw_reg [`NUM_SW_REGS];

   // Strap dependent reset words
   reg_data_t rst_ctrl_init;
   reg_data_t glbl_cfg_init;

   //----------------------------------------
   // Reset values
   //----------------------------------------

   // Boot strap releases core 0
   assign rst_ctrl_init = `RST_CTRL_DEFAULT
      | (reg_data_t'(system_strap[`STRAP_RISCV_RESET_MODE]) << `RST_CTRL_BOOT_BIT);

   // Cache bypass on 27:26 and SRAM clock edge on 23:20
   assign glbl_cfg_init = {4'h0,
                           {2{system_strap[`STRAP_RISCV_CACHE_BYPASS]}},
                           2'b00,
                           {4{system_strap[`STRAP_RISCV_SRAM_CLK_EDGE]}},
                           20'h0};

   //----------------------------------------
   // Byte writes
   //----------------------------------------
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         rst_ctrl  <= rst_ctrl_init;
         glbl_cfg  <= glbl_cfg_init;
         mfunc_sel <= `MFUNC_SEL_DEFAULT;
         mailbox   <= '0;
         sw_reg    <= SW_INIT;
      end else if (wr_stb) begin
         for (int b = 0; b < 4; b++) begin
            if (wr_be[b]) begin
               if (reg_sel[`ADDR_RST_CTRL]) begin
                  rst_ctrl[8*b +: 8] <= wr_data[8*b +: 8];
               end
               // Monitor select and spare bits stay zero
               if (reg_sel[`ADDR_GLBL_CFG]) begin
                  glbl_cfg[8*b +: 8] <= wr_data[8*b +: 8] & CFG_MASK[8*b +: 8];
               end
               if (reg_sel[`ADDR_MFUNC_SEL]) begin
                  mfunc_sel[8*b +: 8] <= wr_data[8*b +: 8];
               end
               if (reg_sel[`ADDR_MAILBOX]) begin
                  mailbox[8*b +: 8] <= wr_data[8*b +: 8];
               end
               for (int i = 0; i < `NUM_SW_REGS; i++) begin
                  if (reg_sel[`ADDR_SW_REG0 + i]) begin
                     sw_reg[i][8*b +: 8] <= wr_data[8*b +: 8];
                  end
               end
            end
         end
      end
   end

   //----------------------------------------
   // Read mux
   //----------------------------------------

   // Zero when no register of this bank is selected
   always_comb begin
      bank_rdata = ({32{reg_sel[`ADDR_RST_CTRL]}}  & rst_ctrl)
                 | ({32{reg_sel[`ADDR_GLBL_CFG]}}  & glbl_cfg)
                 | ({32{reg_sel[`ADDR_MFUNC_SEL]}} & mfunc_sel)
                 | ({32{reg_sel[`ADDR_MAILBOX]}}   & mailbox);
      for (int i = 0; i < `NUM_SW_REGS; i++) begin
         bank_rdata = bank_rdata | ({32{reg_sel[`ADDR_SW_REG0 + i]}} & sw_reg[i]);
      end
   end

   // Config fields
   assign cfg_riscv_ctrl     = glbl_cfg[31:16];
   assign cfg_gpio_dgmode    = glbl_cfg[8];
   assign soft_irq           = glbl_cfg[3];
   assign user_irq           = glbl_cfg[2:0];
   assign cfg_multi_func_sel = mfunc_sel;

   // A clear bit holds its block in reset
   assign cpu_intf_rst_n = rst_ctrl[`RST_BIT_CPU_INTF];
   assign qspim_rst_n    = rst_ctrl[`RST_BIT_QSPIM];
   assign sspim_rst_n    = rst_ctrl[`RST_BIT_SSPIM];
   assign uart_rst_n     = {rst_ctrl[`RST_BIT_UART1], rst_ctrl[`RST_BIT_UART0]};
   assign i2cm_rst_n     = rst_ctrl[`RST_BIT_I2CM];
   assign usb_rst_n      = rst_ctrl[`RST_BIT_USB];
   assign cpu_core_rst_n = rst_ctrl[`RST_BIT_CPU_CORE +: 4];

endmodule

`default_nettype wire

// File: design/irq/irq_stat_ctrl.sv
// Interrupt status and mask
// Syncs USB and I2C sources, sets status from hardware, W1C from software
`timescale 1ns/1ps
`include "glbl_settings.svh"
`default_nettype none

module irq_stat_ctrl
   import glbl_pkg::*;
(
   input  wire logic       mclk,
   input  wire logic       s_reset_n,
   // Decoded write from the bus controller
   input  wire reg_sel_t   reg_sel,
   input  wire logic       wr_stb,
   input  wire reg_data_t  wr_data,
   input  wire reg_be_t    wr_be,
   // Sources
   input  wire logic       usb_intr,
   input  wire logic       i2cm_intr,
   input  wire logic       pwm_intr,
   input  wire logic [2:0] timer_intr,
   input  wire irq_vec_t   gpio_intr,
   output reg_data_t       irq_rdata,
   output irq_vec_t        irq_lines
);

   // Two-stage synchronizers, async domains
   logic [1:0] usb_sync;
   logic [1:0] i2cm_sync;

   irq_vec_t   hw_req;
   irq_vec_t   irq_mask;
   irq_vec_t   irq_stat;
   irq_vec_t   stat_clr;

   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         usb_sync  <= '0;
         i2cm_sync <= '0;
      end else begin
         usb_sync  <= {usb_sync[0], usb_intr};
         i2cm_sync <= {i2cm_sync[0], i2cm_intr};
      end
   end

   // GPIO 7:0 belong to port A, not routed here
   assign hw_req = {gpio_intr[31:8], 2'b00, pwm_intr, usb_sync[1], i2cm_sync[1],
                    timer_intr};

   //----------------------------------------
   // Mask and status
   //----------------------------------------

   // Write 1 clears, per enabled byte
   always_comb begin
      stat_clr = '0;
      for (int b = 0; b < 4; b++) begin
         if (wr_stb && reg_sel[`ADDR_IRQ_STAT] && wr_be[b]) begin
            stat_clr[8*b +: 8] = wr_data[8*b +: 8];
         end
      end
   end

   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         irq_mask <= '0;
         irq_stat <= '0;
      end else begin
         for (int b = 0; b < 4; b++) begin
            if (wr_stb && reg_sel[`ADDR_IRQ_MASK] && wr_be[b]) begin
               irq_mask[8*b +: 8] <= wr_data[8*b +: 8];
            end
         end
         // Set wins over clear
         irq_stat <= (irq_stat & ~stat_clr) | hw_req;
      end
   end

   assign irq_lines = irq_mask & irq_stat;

   assign irq_rdata = ({32{reg_sel[`ADDR_IRQ_MASK]}} & irq_mask)
                    | ({32{reg_sel[`ADDR_IRQ_STAT]}} & irq_stat);

   // A line is only ever raised by a pending status bit
   a_line_needs_stat : assert property (
      @(posedge mclk) disable iff (!s_reset_n)
      (irq_lines & ~irq_stat) == '0
   );

endmodule

`default_nettype wire

// File: design/glbl_reg_top.sv
// Global register block top
// Bus controller, config register bank and interrupt block
`timescale 1ns/1ps
`default_nettype none

module glbl_reg_top
   import glbl_pkg::*;
(
   input  wire logic      mclk,
   input  wire logic      s_reset_n,
   // Register bus
   input  wire logic      reg_cs,
   input  wire logic      reg_wr,
   input  wire reg_addr_t reg_addr,
   input  wire reg_data_t reg_wdata,
   input  wire reg_be_t   reg_be,
   output reg_data_t      reg_rdata,
   output logic           reg_ack,
   // Boot strap, stable during reset
   input  wire reg_data_t system_strap,
   // Interrupt sources
   input  wire logic      usb_intr,
   input  wire logic      i2cm_intr,
   input  wire logic      pwm_intr,
   input  wire logic [2:0] timer_intr,
   input  wire irq_vec_t  gpio_intr,
   // To the core
   output irq_vec_t       irq_lines,
   output logic           soft_irq,
   output logic [2:0]     user_irq,
   output logic [15:0]    cfg_riscv_ctrl,
   output logic           cfg_gpio_dgmode,
   output reg_data_t      cfg_multi_func_sel,
   // Block resets, active low
   output logic [3:0]     cpu_core_rst_n,
   output logic           cpu_intf_rst_n,
   output logic           qspim_rst_n,
   output logic           sspim_rst_n,
   output logic [1:0]     uart_rst_n,
   output logic           i2cm_rst_n,
   output logic           usb_rst_n
);

   // Decoded access towards the register sets
   reg_sel_t  reg_sel;
   logic      wr_stb;
   reg_data_t wr_data;
   reg_be_t   wr_be;

   // Read words returned to the controller
   reg_data_t bank_rdata;
   reg_data_t irq_rdata;

   reg_bus_ctrl u_bus (
      .mclk         (mclk),
      .s_reset_n    (s_reset_n),
      .reg_cs       (reg_cs),
      .reg_wr       (reg_wr),
      .reg_addr     (reg_addr),
      .reg_wdata    (reg_wdata),
      .reg_be       (reg_be),
      .system_strap (system_strap),
      .bank_rdata   (bank_rdata),
      .irq_rdata    (irq_rdata),
      .reg_sel      (reg_sel),
      .wr_stb       (wr_stb),
      .wr_data      (wr_data),
      .wr_be        (wr_be),
      .reg_rdata    (reg_rdata),
      .reg_ack      (reg_ack)
   );

   cfg_reg_bank u_bank (
      .mclk               (mclk),
      .s_reset_n          (s_reset_n),
      .system_strap       (system_strap),
      .reg_sel            (reg_sel),
      .wr_stb             (wr_stb),
      .wr_data            (wr_data),
      .wr_be              (wr_be),
      .bank_rdata         (bank_rdata),
      .soft_irq           (soft_irq),
      .user_irq           (user_irq),
      .cfg_riscv_ctrl     (cfg_riscv_ctrl),
      .cfg_gpio_dgmode    (cfg_gpio_dgmode),
      .cfg_multi_func_sel (cfg_multi_func_sel),
      .cpu_core_rst_n     (cpu_core_rst_n),
      .cpu_intf_rst_n     (cpu_intf_rst_n),
      .qspim_rst_n        (qspim_rst_n),
      .sspim_rst_n        (sspim_rst_n),
      .uart_rst_n         (uart_rst_n),
      .i2cm_rst_n         (i2cm_rst_n),
      .usb_rst_n          (usb_rst_n)
   );

   irq_stat_ctrl u_irq (
      .mclk       (mclk),
      .s_reset_n  (s_reset_n),
      .reg_sel    (reg_sel),
      .wr_stb     (wr_stb),
      .wr_data    (wr_data),
      .wr_be      (wr_be),
      .usb_intr   (usb_intr),
      .i2cm_intr  (i2cm_intr),
      .pwm_intr   (pwm_intr),
      .timer_intr (timer_intr),
      .gpio_intr  (gpio_intr),
      .irq_rdata  (irq_rdata),
      .irq_lines  (irq_lines)
   );

endmodule

`default_nettype wire

// File: dv/tb_glbl_reg.sv
// Testbench for the global register block
// Bus reads and writes checked against a shadow register map,
// field ports, interrupt set and write-1 clear, back-to-back access
`timescale 1ns/1ps
`include "glbl_settings.svh"
`default_nettype none

module tb_glbl_reg
   import glbl_pkg::*;
();

   localparam int        ACK_TIMEOUT = 16;
   localparam int        PWM_BIT     = 5;
   // Reset mode and SRAM clock edge straps set plus spare bits for readback
   localparam reg_data_t STRAP       = 32'h0000_A005;

   logic       mclk;
   logic       s_reset_n;
   logic       reg_cs;
   logic       reg_wr;
   reg_addr_t  reg_addr;
   reg_data_t  reg_wdata;
   reg_be_t    reg_be;
   reg_data_t  reg_rdata;
   logic       reg_ack;
   reg_data_t  system_strap;
   logic       usb_intr;
   logic       i2cm_intr;
   logic       pwm_intr;
   logic [2:0] timer_intr;
   irq_vec_t   gpio_intr;
   irq_vec_t   irq_lines;
   logic       soft_irq;
   logic [2:0] user_irq;
   logic [15:0] cfg_riscv_ctrl;
   logic       cfg_gpio_dgmode;
   reg_data_t  cfg_multi_func_sel;
   logic [3:0] cpu_core_rst_n;
   logic       cpu_intf_rst_n;
   logic       qspim_rst_n;
   logic       sspim_rst_n;
   logic [1:0] uart_rst_n;
   logic       i2cm_rst_n;
   logic       usb_rst_n;

   // Shadow map and interrupt status model
   reg_data_t  shadow [32];
   irq_vec_t   stat_model;
   reg_data_t  lfsr_state;
   int         errors;
   int         tests_run;
   int         tests_failed;
   int         test_errs_start;
   int         ack_count = 0;

   glbl_reg_top u_dut (.*);

   initial begin
      mclk = 1'b0;
      forever #4 mclk = ~mclk;
   end

   // Counts every ack pulse
   always @(negedge mclk) begin
      if (s_reset_n && reg_ack) begin
         ack_count <= ack_count + 1;
      end
   end

   //----------------------------------------
   // Random numbers
   //----------------------------------------
   function automatic reg_data_t lfsr_step(input reg_data_t s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   // One LFSR step per bit taken
   function automatic reg_data_t rand_bits(input int n);
      reg_data_t v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic reg_be_t rand_be();
      reg_data_t v;
      v = rand_bits(4);
      return v[3:0];
   endfunction

   function automatic reg_addr_t rand_addr();
      reg_data_t v;
      v = rand_bits(5);
      return v[4:0];
   endfunction

   //----------------------------------------
   // Reference model
   //----------------------------------------

   // Plain read/write words only since status is W1C
   function automatic bit is_rw(input int a);
      return a == `ADDR_RST_CTRL || a == `ADDR_GLBL_CFG || a == `ADDR_IRQ_MASK
          || a == `ADDR_MFUNC_SEL || a == `ADDR_MAILBOX
          || (a >= `ADDR_SW_REG0 && a < `ADDR_SW_REG0 + `NUM_SW_REGS);
   endfunction

   function automatic void reset_shadow();
      for (int i = 0; i < 32; i++) begin
         shadow[i] = '0;
      end
      shadow[`ADDR_CHIP_ID]  = `CHIP_ID_WORD;
      shadow[`ADDR_RST_CTRL] = `RST_CTRL_DEFAULT;
      // Boot strap releases core 0
      if (STRAP[`STRAP_RISCV_RESET_MODE]) begin
         shadow[`ADDR_RST_CTRL][`RST_CTRL_BOOT_BIT] = 1'b1;
      end
      if (STRAP[`STRAP_RISCV_CACHE_BYPASS]) begin
         shadow[`ADDR_GLBL_CFG][27:26] = 2'b11;
      end
      if (STRAP[`STRAP_RISCV_SRAM_CLK_EDGE]) begin
         shadow[`ADDR_GLBL_CFG][23:20] = 4'hF;
      end
      shadow[`ADDR_MFUNC_SEL]   = `MFUNC_SEL_DEFAULT;
      shadow[`ADDR_SYS_STRAP]   = STRAP;
      shadow[`ADDR_SW_REG0]     = `SW_SIGNATURE;
      shadow[`ADDR_SW_REG0 + 1] = `SW_RELEASE_DATE;
      shadow[`ADDR_SW_REG0 + 2] = `SW_REVISION;
      stat_model = '0;
   endfunction

   // Expected read word at one address
   function automatic reg_data_t expected_read(input reg_addr_t addr);
      if (int'(addr) == `ADDR_IRQ_STAT) begin
         return stat_model;
      end
      return shadow[addr];
   endfunction

   function automatic void apply_write(input reg_addr_t addr, input reg_data_t data,
                                       input reg_be_t be);
      reg_data_t lanes;
      int        a;
      lanes = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
      a = int'(addr);
      if (a == `ADDR_GLBL_CFG) begin
         shadow[a] = (shadow[a] & ~lanes) | (data & lanes & `GLBL_CFG_MASK);
      end else if (a == `ADDR_IRQ_STAT) begin
         stat_model = stat_model & ~(data & lanes);
      end else if (is_rw(a)) begin
         shadow[a] = (shadow[a] & ~lanes) | (data & lanes);
      end
   endfunction

   //----------------------------------------
   // Checks and bus access
   //----------------------------------------
   task automatic check_value(input reg_data_t got, input reg_data_t exp, input string what);
      if (got !== exp) begin
         errors++;
         $display("error: %0d ns: %s: got %h, expected %h", $time, what, got, exp);
      end
   endtask

   // One access that leaves cs high when keep_cs is set
   task automatic bus_access(input logic wr, input reg_addr_t addr, input reg_data_t data,
                             input reg_be_t be, input logic keep_cs);
      reg_data_t expected;
      int        waited;
      @(posedge mclk);
      reg_cs    <= 1'b1;
      reg_wr    <= wr;
      reg_addr  <= addr;
      reg_wdata <= data;
      reg_be    <= be;
      // Read data is the word before the commit edge
      expected = expected_read(addr);
      if (wr) begin
         apply_write(addr, data, be);
      end
      waited = 0;
      @(negedge mclk);
      while (!reg_ack && waited < ACK_TIMEOUT) begin
         @(negedge mclk);
         waited++;
      end
      if (!reg_ack) begin
         errors++;
         $display("Access to address %0d got no reg_ack within %0d cycles", addr, ACK_TIMEOUT);
      end else if (!wr) begin
         check_value(reg_rdata, expected, $sformatf("read of address %0d", addr));
      end
      if (!keep_cs) begin
         @(posedge mclk);
         reg_cs <= 1'b0;
         reg_wr <= 1'b0;
      end
   endtask

   task automatic reg_write(input reg_addr_t addr, input reg_data_t data, input reg_be_t be);
      bus_access(1'b1, addr, data, be, 1'b0);
   endtask

   task automatic reg_read(input reg_addr_t addr);
      bus_access(1'b0, addr, '0, '0, 1'b0);
   endtask

   // Field and reset ports against the shadow words
   task automatic check_ports(input string tag);
      reg_data_t rst;
      reg_data_t cfg;
      @(negedge mclk);
      rst = shadow[`ADDR_RST_CTRL];
      cfg = shadow[`ADDR_GLBL_CFG];
      check_value(32'(cfg_riscv_ctrl), 32'(cfg[31:16]), {tag, " cfg_riscv_ctrl"});
      check_value(32'(cfg_gpio_dgmode), 32'(cfg[8]), {tag, " cfg_gpio_dgmode"});
      check_value(32'(soft_irq), 32'(cfg[3]), {tag, " soft_irq"});
      check_value(32'(user_irq), 32'(cfg[2:0]), {tag, " user_irq"});
      check_value(cfg_multi_func_sel, shadow[`ADDR_MFUNC_SEL], {tag, " cfg_multi_func_sel"});
      check_value(32'(cpu_intf_rst_n), 32'(rst[`RST_BIT_CPU_INTF]), {tag, " cpu_intf_rst_n"});
      check_value(32'(qspim_rst_n), 32'(rst[`RST_BIT_QSPIM]), {tag, " qspim_rst_n"});
      check_value(32'(sspim_rst_n), 32'(rst[`RST_BIT_SSPIM]), {tag, " sspim_rst_n"});
      check_value(32'(uart_rst_n), 32'({rst[`RST_BIT_UART1], rst[`RST_BIT_UART0]}),
                  {tag, " uart_rst_n"});
      check_value(32'(i2cm_rst_n), 32'(rst[`RST_BIT_I2CM]), {tag, " i2cm_rst_n"});
      check_value(32'(usb_rst_n), 32'(rst[`RST_BIT_USB]), {tag, " usb_rst_n"});
      check_value(32'(cpu_core_rst_n), 32'(rst[`RST_BIT_CPU_CORE +: 4]), {tag, " cpu_core_rst_n"});
      check_value(irq_lines, shadow[`ADDR_IRQ_MASK] & stat_model, {tag, " irq_lines"});
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == test_errs_start) begin
         $display("Test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: %0d mismatches", tests_run, name, errors - test_errs_start);
      end
      test_errs_start = errors;
   endtask

   //----------------------------------------
   // Test sequence
   //----------------------------------------
   initial begin : stimulus
      int        ack_start;
      reg_data_t data;
      reg_data_t gpio_pulse;
      reg_data_t timer_pulse;
      reg_data_t rnd;
      errors          = 0;
      tests_run       = 0;
      tests_failed    = 0;
      test_errs_start = 0;
      lfsr_state      = 32'd8;
      s_reset_n    <= 1'b0;
      reg_cs       <= 1'b0;
      reg_wr       <= 1'b0;
      reg_addr     <= '0;
      reg_wdata    <= '0;
      reg_be       <= '0;
      system_strap <= STRAP;
      usb_intr     <= 1'b0;
      i2cm_intr    <= 1'b0;
      pwm_intr     <= 1'b0;
      timer_intr   <= '0;
      gpio_intr    <= '0;
      reset_shadow();
      repeat (4) @(posedge mclk);
      s_reset_n <= 1'b1;

      // Reset defaults including the strap dependent words
      @(negedge mclk);
      check_value(32'(reg_ack), 32'd0, "reg_ack after reset");
      for (int a = 0; a < 19; a++) begin
         if (a < 6 || a >= 14) begin
            reg_read(reg_addr_t'(a));
         end
      end
      check_ports("reset");
      end_test("reset defaults");

      // Random byte writes followed by readback
      for (int round = 0; round < 2; round++) begin
         for (int a = 0; a < 32; a++) begin
            if (is_rw(a)) begin
               reg_write(reg_addr_t'(a), rand_bits(32), rand_be());
            end
         end
         for (int a = 0; a < 32; a++) begin
            if (is_rw(a)) begin
               reg_read(reg_addr_t'(a));
            end
         end
         check_ports("random writes");
      end
      end_test("byte writes and readback");

      // Unused and read-only addresses
      for (int a = 0; a < 32; a++) begin
         if (!is_rw(a) && a != `ADDR_IRQ_STAT) begin
            reg_write(reg_addr_t'(a), rand_bits(32), rand_be());
         end
      end
      for (int a = 0; a < 32; a++) begin
         reg_read(reg_addr_t'(a));
      end
      end_test("unused and read-only addresses");

      // Source pulses with USB and I2C held for 3 cycles
      reg_write(`ADDR_IRQ_MASK, rand_bits(32), 4'hF);
      gpio_pulse  = rand_bits(32);
      timer_pulse = rand_bits(3);
      @(posedge mclk);
      timer_intr <= timer_pulse[2:0];
      pwm_intr   <= 1'b1;
      gpio_intr  <= gpio_pulse;
      usb_intr   <= 1'b1;
      i2cm_intr  <= 1'b1;
      @(posedge mclk);
      timer_intr <= '0;
      pwm_intr   <= 1'b0;
      gpio_intr  <= '0;
      repeat (2) @(posedge mclk);
      usb_intr   <= 1'b0;
      i2cm_intr  <= 1'b0;
      // GPIO 31:8, zeros, PWM, USB, I2C, timers
      stat_model = {gpio_pulse[31:8], 2'b00, 1'b1, 1'b1, 1'b1, timer_pulse[2:0]};
      reg_read(`ADDR_IRQ_STAT);
      reg_read(`ADDR_IRQ_MASK);
      check_ports("interrupt set");
      end_test("interrupt status set");

      // Write 1 clear with PWM held high and its byte always enabled
      @(posedge mclk);
      pwm_intr <= 1'b1;
      for (int round = 0; round < 3; round++) begin
         data = rand_bits(32) | (32'd1 << PWM_BIT);
         reg_write(`ADDR_IRQ_STAT, data, rand_be() | 4'b0001);
         // Held source sets its bit again
         stat_model[PWM_BIT] = 1'b1;
         reg_read(`ADDR_IRQ_STAT);
         check_ports("interrupt clear");
      end
      @(posedge mclk);
      pwm_intr <= 1'b0;
      reg_write(`ADDR_IRQ_STAT, 32'hFFFF_FFFF, 4'hF);
      reg_read(`ADDR_IRQ_STAT);
      check_ports("interrupt clear all");
      end_test("interrupt write-1 clear");

      // cs stays high between accesses
      ack_start = ack_count;
      for (int i = 0; i < 12; i++) begin
         rnd  = rand_bits(1);
         data = rand_bits(32);
         bus_access(rnd[0], rand_addr(), data, rand_be(), i < 11);
      end
      check_value(reg_data_t'(ack_count - ack_start), 32'd12, "acks for back-to-back accesses");
      check_ports("back-to-back");
      end_test("back-to-back access");

      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
+incdir+common
common/glbl_pkg.sv
design/reg_bus_ctrl.sv
design/cfg_reg_bank.sv
design/irq/irq_stat_ctrl.sv
design/glbl_reg_top.sv
dv/tb_glbl_reg.sv

// File: Makefile
# Verilator build for the global register block testbench

TOP = tb_glbl_reg

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
